// File: logic/idx_settings.svh
/* indexed address unit settings.
   bus widths and index register count shared across the design. */
`ifndef IDX_SETTINGS_SVH
`define IDX_SETTINGS_SVH

// cpu address bus width.
`define IDX_ADDR_W 16

// axi4-lite read data width, four byte lanes.
`define IDX_AXI_DATA_W 32

// x, y, u and s.
`define IDX_NUM_REGS 4

`endif

// File: logic/idx_types_pkg.sv
/* indexed address unit vector types.
   addresses, data bytes, offsets and register selects. */
`include "idx_settings.svh"

package idx_types_pkg;

    // cpu address.
    typedef logic [`IDX_ADDR_W-1:0] addr_t;

    // memory data byte.
    typedef logic [7:0] byte_t;

    // 16-bit offset or big-endian pointer.
    typedef logic [15:0] word_t;

    // picks one of x, y, u, s.
    typedef logic [$clog2(`IDX_NUM_REGS)-1:0] reg_sel_t;

endpackage

// File: logic/idx_mode_pkg.sv
/* indexed address unit enums.
   postbyte modes and the state machines of both pipeline stages. */
package idx_mode_pkg;

    // decoded postbyte addressing mode.
    typedef enum logic [3:0] {
        inc1,
        inc2,
        dec1,
        dec2,
        zero_off,
        acc_b,
        acc_a,
        ext8,
        ext16,
        acc_d,
        short5,
        none
    } idx_mode_t;

    // front stage fsm.
    typedef enum logic [1:0] {
        fs_idle,
        fs_fetch_hi,
        fs_fetch_lo,
        fs_hand_off
    } front_state_t;

    // indirect stage fsm.
    typedef enum logic [1:0] {
        is_idle,
        is_read_hi,
        is_read_lo,
        is_respond
    } ind_state_t;

endpackage

// File: logic/idx_mem_if.sv
/* byte read port between a pipeline stage and the memory arbiter. */
interface idx_mem_if
    import idx_types_pkg::*;
();

    // request side, held until gnt.
    addr_t addr;
    logic  req;
    // one-cycle grant pulse.
    logic  gnt;
    // byte returned with a one-cycle rvalid.
    byte_t rdata;
    logic  rvalid;

    modport requester (
        output addr, req,
        input  gnt, rdata, rvalid
    );

    modport arbiter (
        input  addr, req,
        output gnt, rdata, rvalid
    );

endinterface

// File: logic/idx_stage_if.sv
/* handoff of a formed address from the front stage to the indirect stage. */
interface idx_stage_if
    import idx_types_pkg::*;
();

    logic  valid;
    logic  ready;
    // effective address before any pointer lookup.
    addr_t ea;
    logic  indirect;
    addr_t next_pc;

    modport source (
        output valid, ea, indirect, next_pc,
        input  ready
    );

    modport sink (
        input  valid, ea, indirect, next_pc,
        output ready
    );

endinterface

// File: logic/idx_regfile.sv
/* index register file, x y u s.
   front stage read and update ports, host read and write ports. */
`include "idx_settings.svh"

module idx_regfile
    import idx_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     host_wr_en,
    input  reg_sel_t host_wr_sel,
    input  addr_t    host_wr_data,
    input  logic     upd_en,
    input  reg_sel_t upd_sel,
    input  addr_t    upd_data,
    input  reg_sel_t rd_sel_a,
    output addr_t    rd_data_a,
    input  reg_sel_t rd_sel_b,
    output addr_t    rd_data_b
);

    addr_t regs [`IDX_NUM_REGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `IDX_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (host_wr_en) begin
                regs[host_wr_sel] <= host_wr_data;
            end
            // later assignment wins on the same register.
            if (upd_en) begin
                regs[upd_sel] <= upd_data;
            end
        end
    end

    // port a feeds the front stage.
    assign rd_data_a = regs[rd_sel_a];
    // port b feeds the host.
    assign rd_data_b = regs[rd_sel_b];

endmodule

// File: logic/idx_front.sv
/* front stage of the indexed address unit.
   decodes the postbyte, fetches extension bytes and forms the address. */
module idx_front
    import idx_types_pkg::*;
    import idx_mode_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         req_valid,
    output logic         req_ready,
    input  addr_t        req_pc,
    input  byte_t        req_postbyte,
    input  byte_t        req_a,
    input  byte_t        req_b,
    output reg_sel_t     rf_sel,
    input  addr_t        rf_data,
    output logic         upd_en,
    output reg_sel_t     upd_sel,
    output addr_t        upd_data,
    idx_mem_if.requester mem,
    idx_stage_if.source  stage
);

    front_state_t state;
    idx_mode_t    mode;
    idx_mode_t    req_mode;
    logic         ind_q;
    logic         pending;
    logic         take;
    addr_t        base;
    addr_t        cur_pc;
    addr_t        ea_q;
    addr_t        req_ea;
    byte_t        hi_byte;
    word_t        req_off;
    word_t        ext_off;

    function automatic idx_mode_t decode(byte_t pb);
        idx_mode_t m;
        if (pb[7]) begin
            m = short5;
        end else begin
            case (pb[3:0])
                4'b0000: m = inc1;
                4'b0001: m = inc2;
                4'b0010: m = dec1;
                4'b0011: m = dec2;
                4'b0100: m = zero_off;
                4'b0101: m = acc_b;
                4'b0110: m = acc_a;
                4'b1000, 4'b1100: m = ext8;
                4'b1001, 4'b1101: m = ext16;
                4'b1011: m = acc_d;
                default: m = none;
            endcase
        end
        return m;
    endfunction

    // a request is taken only in idle.
    assign req_ready = (state == fs_idle);
    assign take = req_valid && req_ready;
    assign req_mode = decode(req_postbyte);

    // offset for modes without extension bytes.
    always_comb begin
        case (req_mode)
            inc1:    req_off = 16'h0001;
            inc2:    req_off = 16'h0002;
            dec1:    req_off = 16'hffff;
            dec2:    req_off = 16'hfffe;
            acc_b:   req_off = {{8{req_b[7]}}, req_b};
            acc_a:   req_off = {{8{req_a[7]}}, req_a};
            acc_d:   req_off = {req_a, req_b};
            short5:  req_off = {{11{req_postbyte[4]}}, req_postbyte[4:0]};
            default: req_off = 16'h0000;
        endcase
    end

    // register select from bits 6:5, read during the handshake.
    assign rf_sel = req_postbyte[6:5];
    assign req_ea = rf_data + req_off;

    // auto inc/dec writes back on the handshake cycle.
    assign upd_en   = take && (req_mode inside {inc1, inc2, dec1, dec2});
    assign upd_sel  = req_postbyte[6:5];
    assign upd_data = req_ea;

    // extension offset, completed by the last fetched byte.
    assign ext_off = (mode == ext16) ? {hi_byte, mem.rdata}
                                     : {{8{mem.rdata[7]}}, mem.rdata};

    // extension bytes start right after the postbyte.
    assign mem.req  = (state == fs_fetch_hi || state == fs_fetch_lo) && !pending;
    assign mem.addr = cur_pc;

    assign stage.valid    = (state == fs_hand_off);
    assign stage.ea       = ea_q;
    assign stage.indirect = ind_q;
    assign stage.next_pc  = cur_pc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= fs_idle;
            pending <= 1'b0;
        end else begin
            // one read in flight, from grant to data.
            if (mem.gnt) begin
                pending <= 1'b1;
            end else if (mem.rvalid) begin
                pending <= 1'b0;
            end
            case (state)
                fs_idle: begin
                    if (take) begin
                        if (req_mode == ext16) begin
                            state <= fs_fetch_hi;
                        end else if (req_mode == ext8) begin
                            state <= fs_fetch_lo;
                        end else begin
                            state <= fs_hand_off;
                        end
                    end
                end
                fs_fetch_hi: begin
                    if (mem.rvalid) begin
                        state <= fs_fetch_lo;
                    end
                end
                fs_fetch_lo: begin
                    if (mem.rvalid) begin
                        state <= fs_hand_off;
                    end
                end
                fs_hand_off: begin
                    // waits here while the indirect stage is busy.
                    if (stage.ready) begin
                        state <= fs_idle;
                    end
                end
                default: state <= fs_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            mode   <= req_mode;
            // short offsets use bit 4 as sign, never indirect.
            ind_q  <= !req_postbyte[7] && req_postbyte[4];
            base   <= rf_data;
            cur_pc <= req_pc;
            ea_q   <= req_ea;
        end
        // each fetched byte advances next_pc.
        if (mem.rvalid) begin
            cur_pc  <= cur_pc + 1'b1;
            hi_byte <= mem.rdata;
        end
        if (state == fs_fetch_lo && mem.rvalid) begin
            ea_q <= base + ext_off;
        end
    end

endmodule

// File: logic/idx_indirect.sv
/* indirect stage of the indexed address unit.
   reads a big-endian pointer when needed and holds the response. */
module idx_indirect
    import idx_types_pkg::*;
    import idx_mode_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    idx_stage_if.sink    stage,
    idx_mem_if.requester mem,
    output logic         rsp_valid,
    input  logic         rsp_ready,
    output addr_t        rsp_ea,
    output addr_t        rsp_next_pc
);

    ind_state_t state;
    logic       pending;
    logic       take;
    addr_t      ea_q;
    addr_t      pc_q;
    addr_t      res_q;
    byte_t      hi_byte;
    word_t      ptr;

    assign stage.ready = (state == is_idle);
    assign take = stage.valid && stage.ready;

    // high byte at ea, low byte at ea + 1.
    assign mem.req  = (state == is_read_hi || state == is_read_lo) && !pending;
    assign mem.addr = (state == is_read_lo) ? addr_t'(ea_q + 1'b1) : ea_q;
    assign ptr = {hi_byte, mem.rdata};

    assign rsp_valid   = (state == is_respond);
    assign rsp_ea      = res_q;
    assign rsp_next_pc = pc_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= is_idle;
            pending <= 1'b0;
        end else begin
            if (mem.gnt) begin
                pending <= 1'b1;
            end else if (mem.rvalid) begin
                pending <= 1'b0;
            end
            case (state)
                is_idle: begin
                    if (take) begin
                        state <= stage.indirect ? is_read_hi : is_respond;
                    end
                end
                is_read_hi: begin
                    if (mem.rvalid) begin
                        state <= is_read_lo;
                    end
                end
                is_read_lo: begin
                    if (mem.rvalid) begin
                        state <= is_respond;
                    end
                end
                is_respond: begin
                    if (rsp_ready) begin
                        state <= is_idle;
                    end
                end
                default: state <= is_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ea_q  <= stage.ea;
            pc_q  <= stage.next_pc;
            // direct items answer with the formed address.
            res_q <= stage.ea;
        end
        if (state == is_read_hi && mem.rvalid) begin
            hi_byte <= mem.rdata;
        end
        if (state == is_read_lo && mem.rvalid) begin
            res_q <= ptr;
        end
    end

endmodule

// File: logic/mem_arbiter.sv
/* round-robin arbiter of two byte read ports onto one axi4-lite read channel.
   one read at a time with the byte lane picked by the low address bits. */
`include "idx_settings.svh"

module mem_arbiter
    import idx_types_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    idx_mem_if.arbiter                 port0,
    idx_mem_if.arbiter                 port1,
    output addr_t                      araddr,
    output logic                       arvalid,
    input  logic                       arready,
    input  logic [`IDX_AXI_DATA_W-1:0] rdata,
    input  logic [1:0]                 rresp,
    input  logic                       rvalid,
    output logic                       rready
);

    logic  ar_pend;
    logic  r_pend;
    logic  busy;
    logic  start;
    logic  pick;
    logic  last;
    byte_t lane_byte;

    assign busy = ar_pend || r_pend;

    // port1 wins alone, or on a tie when port0 was served last.
    assign pick  = port1.req && (!port0.req || !last);
    assign start = !busy && (port0.req || port1.req);

    // grant pulses on the cycle the address is captured.
    assign port0.gnt = start && !pick;
    assign port1.gnt = start && pick;

    assign arvalid = ar_pend;
    // ready for r once the address is accepted.
    assign rready = r_pend;

    // lane from the captured address. rresp plays no part.
    assign lane_byte = rdata[araddr[1:0]*8 +: 8];

    // the port served last owns the read in flight.
    assign port0.rdata  = lane_byte;
    assign port1.rdata  = lane_byte;
    assign port0.rvalid = r_pend && rvalid && !last;
    assign port1.rvalid = r_pend && rvalid && last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ar_pend <= 1'b0;
            r_pend  <= 1'b0;
            last    <= 1'b0;
        end else begin
            if (start) begin
                ar_pend <= 1'b1;
                last    <= pick;
            end
            if (ar_pend && arready) begin
                ar_pend <= 1'b0;
                r_pend  <= 1'b1;
            end
            if (r_pend && rvalid) begin
                r_pend <= 1'b0;
            end
        end
    end

    // address held stable while arvalid is high.
    always_ff @(posedge clk) begin
        if (start) begin
            araddr <= pick ? port1.addr : port0.addr;
        end
    end

endmodule

// File: logic/idx_agu_top.sv
/* indexed effective address unit, top level.
   register file, front and indirect stages sharing one axi4-lite reader. */
`include "idx_settings.svh"

module idx_agu_top
    import idx_types_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    // request from the sequencer.
    input  logic                       req_valid,
    output logic                       req_ready,
    input  addr_t                      req_pc,
    input  byte_t                      req_postbyte,
    input  byte_t                      req_a,
    input  byte_t                      req_b,
    // response.
    output logic                       rsp_valid,
    input  logic                       rsp_ready,
    output addr_t                      rsp_ea,
    output addr_t                      rsp_next_pc,
    // host register access.
    input  logic                       reg_wr_en,
    input  reg_sel_t                   reg_wr_sel,
    input  addr_t                      reg_wr_data,
    input  reg_sel_t                   reg_rd_sel,
    output addr_t                      reg_rd_data,
    // axi4-lite read channel.
    output addr_t                      araddr,
    output logic                       arvalid,
    input  logic                       arready,
    input  logic [`IDX_AXI_DATA_W-1:0] rdata,
    input  logic [1:0]                 rresp,
    input  logic                       rvalid,
    output logic                       rready
);

    reg_sel_t rf_sel;
    addr_t    rf_data;
    logic     upd_en;
    reg_sel_t upd_sel;
    addr_t    upd_data;

    // front stage on port0, indirect stage on port1.
    idx_mem_if   front_mem ();
    idx_mem_if   ind_mem ();
    idx_stage_if handoff ();

    idx_regfile u_regfile (
        .clk          (clk),
        .rst          (rst),
        .host_wr_en   (reg_wr_en),
        .host_wr_sel  (reg_wr_sel),
        .host_wr_data (reg_wr_data),
        .upd_en       (upd_en),
        .upd_sel      (upd_sel),
        .upd_data     (upd_data),
        .rd_sel_a     (rf_sel),
        .rd_data_a    (rf_data),
        .rd_sel_b     (reg_rd_sel),
        .rd_data_b    (reg_rd_data)
    );

    idx_front u_front (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_pc       (req_pc),
        .req_postbyte (req_postbyte),
        .req_a        (req_a),
        .req_b        (req_b),
        .rf_sel       (rf_sel),
        .rf_data      (rf_data),
        .upd_en       (upd_en),
        .upd_sel      (upd_sel),
        .upd_data     (upd_data),
        .mem          (front_mem.requester),
        .stage        (handoff.source)
    );

    idx_indirect u_indirect (
        .clk          (clk),
        .rst          (rst),
        .stage        (handoff.sink),
        .mem          (ind_mem.requester),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_ea       (rsp_ea),
        .rsp_next_pc  (rsp_next_pc)
    );

    mem_arbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .port0        (front_mem.arbiter),
        .port1        (ind_mem.arbiter),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready)
    );

endmodule

// File: sim/tb_idx_agu.sv
/* testbench for the indexed effective address unit.
   axi4-lite memory model, shadow index registers and an in-order response checker. */
module tb_idx_agu;

    localparam int TIMEOUT_CYCLES = 2000;

    // expected outcome of one request.
    typedef struct packed {
        logic [15:0] ea;
        logic [15:0] next_pc;
        logic        wb;
        logic [15:0] wb_val;
    } exp_t;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    logic [15:0] req_pc;
    logic [7:0]  req_postbyte;
    logic [7:0]  req_a;
    logic [7:0]  req_b;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [15:0] rsp_ea;
    logic [15:0] rsp_next_pc;
    logic        reg_wr_en;
    logic [1:0]  reg_wr_sel;
    logic [15:0] reg_wr_data;
    logic [1:0]  reg_rd_sel;
    logic [15:0] reg_rd_data;
    logic [15:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    // model state.
    logic [7:0]  mem [0:65535];
    logic [15:0] shadow [4];
    logic [31:0] lfsr;
    logic        rsp_random;
    exp_t        exp_q [$];
    string       name_q [$];
    int          mismatches = 0;
    int          other_errs = 0;
    int          sent_cnt = 0;
    int          rsp_cnt = 0;

    idx_agu_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_pc       (req_pc),
        .req_postbyte (req_postbyte),
        .req_a        (req_a),
        .req_b        (req_b),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_ea       (rsp_ea),
        .rsp_next_pc  (rsp_next_pc),
        .reg_wr_en    (reg_wr_en),
        .reg_wr_sel   (reg_wr_sel),
        .reg_wr_data  (reg_wr_data),
        .reg_rd_sel   (reg_rd_sel),
        .reg_rd_data  (reg_rd_data),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready)
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // expected address from the shadow registers and model memory.
    function automatic exp_t ref_model(input logic [7:0] pb, input logic [15:0] pc,
                                       input logic [7:0] a, input logic [7:0] b);
        exp_t        e;
        logic [15:0] base;
        logic [15:0] off;
        logic [15:0] pc1;
        logic [15:0] ea1;
        logic [15:0] nbytes;
        logic        ind;
        e = '0;
        base = shadow[pb[6:5]];
        pc1 = pc + 16'd1;
        off = 16'h0000;
        nbytes = 16'd0;
        ind = 1'b0;
        if (pb[7]) begin
            // 5-bit signed offset.
            off = {{11{pb[4]}}, pb[4:0]};
        end else begin
            ind = pb[4];
            case (pb[3:0])
                4'h0: off = 16'h0001;
                4'h1: off = 16'h0002;
                4'h2: off = 16'hffff;
                4'h3: off = 16'hfffe;
                4'h5: off = {{8{b[7]}}, b};
                4'h6: off = {{8{a[7]}}, a};
                4'h8, 4'hc: begin
                    off = {{8{mem[pc][7]}}, mem[pc]};
                    nbytes = 16'd1;
                end
                4'h9, 4'hd: begin
                    off = {mem[pc], mem[pc1]};
                    nbytes = 16'd2;
                end
                4'hb: off = {a, b};
                default: off = 16'h0000;
            endcase
            // auto inc and dec modes.
            e.wb = (pb[3:2] == 2'b00);
        end
        e.wb_val = base + off;
        e.ea = base + off;
        if (ind) begin
            // big-endian pointer.
            ea1 = e.ea + 16'd1;
            e.ea = {mem[e.ea], mem[ea1]};
        end
        e.next_pc = pc + nbytes;
        return e;
    endfunction

    task automatic check_val(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            mismatches++;
        end
    endtask

    // predicts the outcome, then holds req_valid until the handshake.
    task automatic send_req(input string name, input logic [7:0] pb, input logic [15:0] pc,
                            input logic [7:0] a, input logic [7:0] b);
        exp_t e;
        int   t;
        e = ref_model(pb, pc, a, b);
        exp_q.push_back(e);
        name_q.push_back($sformatf("%s pb %h", name, pb));
        if (e.wb) begin
            shadow[pb[6:5]] = e.wb_val;
        end
        sent_cnt++;
        req_valid = 1'b1;
        req_postbyte = pb;
        req_pc = pc;
        req_a = a;
        req_b = b;
        t = 0;
        @(negedge clk);
        while (!req_ready && t < TIMEOUT_CYCLES) begin
            @(negedge clk);
            t++;
        end
        if (!req_ready) begin
            $display("timeout, request %s was never accepted", name);
            other_errs++;
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    // waits until every expected response has been seen.
    task automatic drain();
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout, %0d responses never arrived", exp_q.size());
            other_errs++;
            exp_q.delete();
            name_q.delete();
        end
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input logic [1:0] sel, input logic [15:0] data);
        reg_wr_en = 1'b1;
        reg_wr_sel = sel;
        reg_wr_data = data;
        @(posedge clk);
        #1;
        reg_wr_en = 1'b0;
        shadow[sel] = data;
    endtask

    task automatic read_reg(input logic [1:0] sel, output logic [15:0] data);
        reg_rd_sel = sel;
        @(negedge clk);
        data = reg_rd_data;
        @(posedge clk);
        #1;
    endtask

    task automatic check_regs(input string name);
        logic [15:0] v;
        for (int s = 0; s < 4; s++) begin
            read_reg(2'(s), v);
            check_val($sformatf("%s r%0d", name, s), shadow[s], v);
        end
    endtask

    task automatic randomize_regs();
        for (int s = 0; s < 4; s++) begin
            write_reg(2'(s), 16'(rand_bits(16)));
        end
    endtask

    // axi4-lite read slave, random ar and r delays.
    initial begin : axi_slave
        logic [15:0] a;
        logic [15:0] base;
        int          d;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = 2'b00;
        forever begin
            @(posedge clk);
            #2;
            if (arvalid) begin
                d = int'(rand_bits(2));
                repeat (d) begin
                    @(posedge clk);
                    #2;
                end
                a = araddr;
                arready = 1'b1;
                @(posedge clk);
                #2;
                arready = 1'b0;
                check_val("axi rready after ar", 16'd1, {15'd0, rready});
                d = int'(rand_bits(2));
                repeat (d) begin
                    @(posedge clk);
                    #2;
                end
                // whole word, byte lane follows the low address bits.
                base = {a[15:2], 2'b00};
                rdata = {mem[base + 16'd3], mem[base + 16'd2], mem[base + 16'd1], mem[base]};
                rvalid = 1'b1;
                @(posedge clk);
                #2;
                rvalid = 1'b0;
            end
        end
    end

    initial begin : rsp_ready_drive
        rsp_ready = 1'b1;
        forever begin
            @(posedge clk);
            #3;
            if (rsp_random) begin
                rsp_ready = (rand_bits(2) != 0);
            end else begin
                rsp_ready = 1'b1;
            end
        end
    end

    // in-order response compare.
    initial begin : rsp_checker
        exp_t  e;
        string nm;
        forever begin
            @(negedge clk);
            if (!rst && rsp_valid && rsp_ready) begin
                rsp_cnt++;
                if (exp_q.size() == 0) begin
                    $display("unexpected response with nothing outstanding, ea %h", rsp_ea);
                    other_errs++;
                end else begin
                    e = exp_q.pop_front();
                    nm = name_q.pop_front();
                    check_val({nm, " ea"}, e.ea, rsp_ea);
                    check_val({nm, " next_pc"}, e.next_pc, rsp_next_pc);
                end
            end
        end
    end

    initial begin : main
        logic [7:0] pb;
        lfsr = 32'h267d12a5;
        rst = 1'b1;
        rsp_random = 1'b0;
        req_valid = 1'b0;
        req_pc = '0;
        req_postbyte = '0;
        req_a = '0;
        req_b = '0;
        reg_wr_en = 1'b0;
        reg_wr_sel = '0;
        reg_wr_data = '0;
        reg_rd_sel = '0;
        for (int i = 0; i < 65536; i++) begin
            mem[16'(i)] = 8'(rand_bits(8));
        end
        for (int s = 0; s < 4; s++) begin
            shadow[s] = 16'h0000;
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle outputs after reset.
        @(negedge clk);
        check_val("reset req_ready", 16'd1, {15'd0, req_ready});
        check_val("reset rsp_valid", 16'd0, {15'd0, rsp_valid});
        check_val("reset arvalid", 16'd0, {15'd0, arvalid});
        check_val("reset rready", 16'd0, {15'd0, rready});
        @(posedge clk);
        #1;
        check_regs("reset regs");

        // constant, accumulator and zero modes.
        randomize_regs();
        for (int n = 4; n < 16; n++) begin
            if (!(n inside {8, 9, 12, 13})) begin
                for (int s = 0; s < 4; s++) begin
                    pb = {1'b0, 2'(s), 1'b0, 4'(n)};
                    send_req("const_acc", pb, 16'(rand_bits(16)), 8'(rand_bits(8)),
                             8'(rand_bits(8)));
                end
            end
        end
        // every 5-bit offset.
        for (int off = 0; off < 32; off++) begin
            pb = {1'b1, 2'(off), 5'(off)};
            send_req("short5", pb, 16'(rand_bits(16)), 8'(rand_bits(8)), 8'(rand_bits(8)));
        end
        drain();

        // one and two extension bytes.
        randomize_regs();
        for (int rep = 0; rep < 2; rep++) begin
            for (int n = 8; n < 14; n++) begin
                if (n inside {8, 9, 12, 13}) begin
                    for (int s = 0; s < 4; s++) begin
                        pb = {1'b0, 2'(s), 1'b0, 4'(n)};
                        send_req("ext", pb, 16'(rand_bits(16)), 8'(rand_bits(8)),
                                 8'(rand_bits(8)));
                    end
                end
            end
        end
        drain();

        // auto inc and dec, twice on the same register.
        for (int s = 0; s < 4; s++) begin
            for (int n = 0; n < 4; n++) begin
                write_reg(2'(s), 16'(rand_bits(16)));
                pb = {1'b0, 2'(s), 1'b0, 4'(n)};
                send_req("autoinc first", pb, 16'(rand_bits(16)), 8'h00, 8'h00);
                send_req("autoinc second", pb, 16'(rand_bits(16)), 8'h00, 8'h00);
                drain();
                check_regs("autoinc regs");
            end
        end

        // indirect forms, 0111 and 1010 are plain zero.
        randomize_regs();
        for (int n = 0; n < 14; n++) begin
            if (n != 7 && n != 10) begin
                for (int s = 0; s < 4; s++) begin
                    pb = {1'b0, 2'(s), 1'b1, 4'(n)};
                    send_req("indirect", pb, 16'(rand_bits(16)), 8'(rand_bits(8)),
                             8'(rand_bits(8)));
                end
            end
        end
        drain();
        check_regs("indirect regs");

        // random stream under response back-pressure.
        randomize_regs();
        rsp_random = 1'b1;
        for (int k = 0; k < 200; k++) begin
            send_req("stream", 8'(rand_bits(8)), 16'(rand_bits(16)), 8'(rand_bits(8)),
                     8'(rand_bits(8)));
        end
        drain();
        rsp_random = 1'b0;
        check_regs("stream regs");

        // quiet window to catch stray responses.
        repeat (20) @(posedge clk);
        check_val("response count", 16'(sent_cnt), 16'(rsp_cnt));
        $display("errors: %0d mismatches, %0d other", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+logic
logic/idx_types_pkg.sv
logic/idx_mode_pkg.sv
logic/idx_mem_if.sv
logic/idx_stage_if.sv
logic/idx_regfile.sv
logic/idx_front.sv
logic/idx_indirect.sv
logic/mem_arbiter.sv
logic/idx_agu_top.sv
sim/tb_idx_agu.sv
